//--- src.f
logic/pcs_pkg.sv
logic/pcs_enc.sv
logic/pcs_scrambler.sv
logic/pcs_am_insert.sv
logic/pcs_gearbox_tx.sv
logic/pcs_tx.sv
tests/pcs_tx_tb.sv

//--- Makefile
# Verilator build and run of the 40G PCS transmit testbench

VERILATOR ?= verilator
TOP       ?= pcs_tx_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/pcs_tx_tb.sv
`timescale 1ns/1ps
module pcs_tx_tb import pcs_pkg::*; ();

localparam int          AM_P      = 20;                  // short marker period
localparam logic [57:0] SEED      = 58'h1234_5678_9abc_def;
localparam int          NROWS     = 24;
localparam int          NPASS     = 2;                   // table applied twice
localparam int          NWORDS    = NROWS*NPASS;
localparam int          WDOG_CYC  = 40*NWORDS + 200;
localparam int          GB_PERIOD = 33;                  // 32 blocks in 33 words

localparam logic [3:0] K_DATA  = 4'd0;
localparam logic [3:0] K_IDLE  = 4'd1;
localparam logic [3:0] K_START = 4'd2;
localparam logic [3:0] K_TERM  = 4'd3;
localparam logic [3:0] K_ERR   = 4'd4;

// control block with idle codes, as held out of reset
localparam logic [65:0] RAW_IDLE = {56'h0, 8'h1e, 2'b10};

// one nibble of kind and one byte of keep per lane, lane 3 in the msbs
typedef struct packed {
	logic [15:0] kind;
	logic [31:0] keep;
	logic [1:0]  dsel; // 0 random, 1 pattern, 2 all ones
} stim_row_t;

stim_row_t stim_tab [NROWS] = '{
	'{16'h1111, 32'h0000_0000, 2'd0},
	'{16'h1111, 32'h0000_0000, 2'd0},
	'{16'h0002, 32'h0000_0000, 2'd0}, // start on lane 0
	'{16'h0000, 32'h0000_0000, 2'd0},
	'{16'h0000, 32'h0000_0000, 2'd1},
	'{16'h0000, 32'h0000_0000, 2'd2},
	'{16'h3333, 32'h0001_0307, 2'd0}, // term counts 3 2 1 0
	'{16'h1111, 32'h0000_0000, 2'd0},
	'{16'h0002, 32'h0000_0000, 2'd1},
	'{16'h0000, 32'h0000_0000, 2'd0},
	'{16'h3333, 32'h7f3f_1f0f, 2'd0}, // term counts 4 5 6 7
	'{16'h4444, 32'h0000_0000, 2'd0}, // error everywhere
	'{16'h0020, 32'h0000_0000, 2'd0},
	'{16'h3000, 32'h0300_0000, 2'd1},
	'{16'h0410, 32'h0000_0000, 2'd2},
	'{16'h0000, 32'h0000_0000, 2'd0},
	'{16'h0030, 32'h0000_7f00, 2'd0},
	'{16'h2222, 32'h0000_0000, 2'd1},
	'{16'h0000, 32'h0000_0000, 2'd0},
	'{16'h0300, 32'h001f_0000, 2'd2},
	'{16'h0003, 32'h0000_0001, 2'd0},
	'{16'h1111, 32'h0000_0000, 2'd0},
	'{16'h0000, 32'h0000_0000, 2'd1},
	'{16'h4321, 32'h000f_0000, 2'd0}  // one of each control kind
};

// 40G marker bytes per lane, M0 in the low byte
logic [23:0] am_bytes [4] = '{24'h477690, 24'he6c4f0, 24'h9b65c5, 24'h3d79a2};

logic                    pcs_clk = 1'b0;
logic                    rst_i;
xgmii_ctrl_t [3:0]       ctrl_i;
logic [255:0]            data_i;
logic [31:0]             keep_i;
logic                    ready_o;
logic                    marker_v_o;
logic [255:0]            serdes_data_o;

logic [191:0] bitbuf [4];          // serial rx bits per lane, lsb oldest
int           bitcnt [4] = '{0, 0, 0, 0};
logic [65:0]  rx_q   [4][$];       // rebuilt 66b blocks
logic [65:0]  exp_q  [4][$];       // expected clear blocks
logic [7:0]   bip_acc [4] = '{8'h0, 8'h0, 8'h0, 8'h0};
logic [57:0]  dsr = SEED;          // descrambler history, msb newest
int           blk_idx  = 0;        // block position on the line
int           data_idx = 0;        // data blocks seen
int           mark_cnt = 0;
int           cyc      = 0;
int           acc_cnt  = 0;        // gearbox accept slots
int           err_cnt  = 0;
int           chk_cnt  = 0;
bit           stim_done = 1'b0;
bit           rx_done   = 1'b0;

pcs_tx #(.AM_PERIOD(AM_P), .SCRAM_SEED(SEED)) pcs_tx_inst (
	.pcs_clk       (pcs_clk),
	.rst_i         (rst_i),
	.ctrl_i        (ctrl_i),
	.data_i        (data_i),
	.keep_i        (keep_i),
	.ready_o       (ready_o),
	.marker_v_o    (marker_v_o),
	.serdes_data_o (serdes_data_o)
);

always #4 pcs_clk = ~pcs_clk;

function automatic xgmii_ctrl_t ctrl_of(input logic [3:0] kind);
	xgmii_ctrl_t c;
	c = '0;
	c.ctrl_v  = (kind != K_DATA);
	c.idle_v  = (kind == K_IDLE);
	c.start_v = (kind == K_START);
	c.term_v  = (kind == K_TERM);
	c.err_v   = (kind == K_ERR);
	return c;
endfunction

function automatic logic [7:0] term_type(input int n);
	case (n)
		0: return 8'h87;
		1: return 8'h99;
		2: return 8'haa;
		3: return 8'hb4;
		4: return 8'hcc;
		5: return 8'hd2;
		6: return 8'he1;
		default: return 8'hff;
	endcase
endfunction

// 66b block {payload, header} as the encoder rules give it
function automatic logic [65:0] encode_lane(input logic [3:0] kind, input logic [7:0] keep,
	input logic [63:0] d);
	logic [63:0] p;
	int          n;
	p = '0;
	n = 0;
	case (kind)
		K_DATA: return {d, 2'b01};
		K_START: begin
			p       = d;
			p[7:0]  = 8'h78; // type replaces byte 0
		end
		K_TERM: begin
			for (int b = 0; b < 8; b++) begin
				if (keep[b]) n++;
			end
			p[7:0] = term_type(n);
			for (int b = 0; b < n && b < 7; b++) begin
				p[8*(b+1) +: 8] = d[8*b +: 8];
			end
		end
		K_ERR: begin
			p[7:0] = 8'h1e;
			for (int j = 0; j < 8; j++) begin
				p[8+7*j +: 7] = 7'h1e;
			end
		end
		default: p[7:0] = 8'h1e; // idle codes are zero
	endcase
	return {p, 2'b10};
endfunction

function automatic logic [63:0] pattern_word(input int row, input int lane);
	logic [63:0] w;
	for (int b = 0; b < 8; b++) begin
		w[8*b +: 8] = 8'(row*16 + lane*4 + b) ^ 8'ha5;
	end
	return w;
endfunction

// bit i of the block lands on parity bit i mod 8
function automatic logic [7:0] bip_of(input logic [65:0] blk);
	logic [7:0] r;
	r = '0;
	for (int i = 0; i < 66; i++) begin
		r[i%8] = r[i%8] ^ blk[i];
	end
	return r;
endfunction

task automatic check_value(input string name, input logic [65:0] exp, input logic [65:0] act);
	chk_cnt++;
	assert (act === exp) else begin
		$display("FAIL %s: expected %h, actual %h", name, exp, act);
		err_cnt++;
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	chk_cnt++;
	assert (act === exp) else begin
		$display("FAIL %s: expected %0b, actual %0b", name, exp, act);
		err_cnt++;
	end
endtask

// x^39 + x^58 self-synchronizing, one bit at a time
task automatic descramble(input logic [63:0] s, output logic [63:0] d);
	for (int i = 0; i < 64; i++) begin
		d[i] = s[i] ^ dsr[19] ^ dsr[0]; // s[n-39], s[n-58]
		dsr  = {s[i], dsr[57:1]};
	end
endtask

task automatic drive_row(input stim_row_t row, input int row_n);
	logic [63:0] w;
	for (int l = 0; l < 4; l++) begin
		case (row.dsel)
			2'd0: w = {$urandom, $urandom};
			2'd1: w = pattern_word(row_n, l);
			default: w = '1;
		endcase
		data_i[64*l +: 64] = w;
		keep_i[8*l +: 8]   = row.keep[8*l +: 8];
		ctrl_i[l]          = ctrl_of(row.kind[4*l +: 4]);
		exp_q[l].push_back(encode_lane(row.kind[4*l +: 4], row.keep[8*l +: 8], w));
	end
endtask

// hold the word until a rising edge sees ready_o
task automatic wait_accept();
	logic taken;
	taken = 1'b0;
	while (!taken) begin
		@(negedge pcs_clk);
		taken = ready_o;
		@(posedge pcs_clk);
		#1;
	end
endtask

// one block position across all four lanes
task automatic take_block();
	logic [65:0] blk [4];
	logic [65:0] mk;
	logic [63:0] pl;
	for (int l = 0; l < 4; l++) begin
		blk[l] = rx_q[l].pop_front();
	end
	if (blk_idx % (AM_P+1) == AM_P) begin
		for (int l = 0; l < 4; l++) begin
			mk = {~{bip_acc[l], am_bytes[l]}, bip_acc[l], am_bytes[l], 2'b10};
			check_value($sformatf("lane%0d marker%0d", l, mark_cnt), mk, blk[l]);
			bip_acc[l] = '0;
		end
		mark_cnt++;
	end else begin
		for (int l = 0; l < 4; l++) begin
			bip_acc[l] = bip_acc[l] ^ bip_of(blk[l]);
		end
		if (data_idx < 2) begin // stage fill left by reset, never scrambled
			for (int l = 0; l < 4; l++) begin
				check_value($sformatf("lane%0d reset fill%0d", l, data_idx), RAW_IDLE, blk[l]);
			end
		end else begin
			for (int l = 0; l < 4; l++) begin // lane order matches the scrambler
				descramble(blk[l][65:2], pl);
				if (exp_q[l].size() > 0) begin
					check_value($sformatf("lane%0d block%0d", l, data_idx-2),
						exp_q[l].pop_front(), {pl, blk[l][1:0]});
				end
			end
			if (stim_done && exp_q[0].size() == 0) rx_done = 1'b1;
		end
		data_idx++;
	end
	blk_idx++;
endtask

// ready and marker timing from gearbox phase and marker period
task automatic check_timing();
	logic stall;
	logic mark_slot;
	stall     = (cyc % GB_PERIOD == GB_PERIOD-1);
	mark_slot = (acc_cnt % (AM_P+1) == AM_P);
	if (cyc == 0) begin
		assert (ready_o === 1'b1 && marker_v_o === 1'b0) else begin
			$display("ready_o not high or marker_v_o not low in the first cycle out of reset");
			err_cnt++;
		end
	end
	check_bit($sformatf("ready_o cycle%0d", cyc), !stall && !mark_slot, ready_o);
	if (!stall) begin
		check_bit($sformatf("marker_v_o slot%0d", acc_cnt), mark_slot, marker_v_o);
		acc_cnt++;
	end
endtask

// outputs settle well before the falling edge
always @(negedge pcs_clk) begin
	if (!rst_i) begin
		check_timing();
		for (int l = 0; l < 4; l++) begin
			bitbuf[l] = bitbuf[l] | (192'(serdes_data_o[64*l +: 64]) << bitcnt[l]);
			bitcnt[l] += 64;
			while (bitcnt[l] >= 66) begin
				rx_q[l].push_back(bitbuf[l][65:0]);
				bitbuf[l] = bitbuf[l] >> 66;
				bitcnt[l] -= 66;
			end
		end
		while (rx_q[0].size() > 0) take_block();
		cyc++;
	end
end

initial begin
	int unsigned seed_ret;
	rst_i  = 1'b1;
	data_i = '0;
	keep_i = '0;
	for (int l = 0; l < 4; l++) begin
		ctrl_i[l] = ctrl_of(K_IDLE);
		bitbuf[l] = '0;
		exp_q[l].push_back(encode_lane(K_IDLE, 8'h0, 64'h0)); // encoder reset content
	end
	seed_ret = $urandom(32'hd7f7);
	repeat (8) @(posedge pcs_clk);
	#1;
	rst_i = 1'b0;
	for (int p = 0; p < NPASS; p++) begin
		for (int r = 0; r < NROWS; r++) begin
			drive_row(stim_tab[r], p*NROWS + r);
			wait_accept();
		end
	end
	for (int l = 0; l < 4; l++) begin
		ctrl_i[l] = ctrl_of(K_IDLE); // idle fill while the tail drains
	end
	data_i    = '0;
	keep_i    = '0;
	stim_done = 1'b1;
	wait (rx_done);
	@(posedge pcs_clk);
	$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
	if (err_cnt == 0) begin
		$display("No errors");
	end else begin
		$display("Errors found");
	end
	$finish;
end

// bound on the whole run
initial begin
	repeat (WDOG_CYC) @(posedge pcs_clk);
	$display("timeout after %0d cycles, receive side still waiting for blocks", WDOG_CYC);
	$display("Errors found");
	$finish;
end

endmodule

//--- logic/pcs_tx.sv
`timescale 1ns/1ps
module pcs_tx import pcs_pkg::*; #(
	parameter int           AM_PERIOD  = 16383, // data blocks per lane between markers
	parameter scram_state_t SCRAM_SEED = '1
)(
	input  logic                       pcs_clk,
	input  logic                       rst_i,
	input  xgmii_ctrl_t [LANE_N-1:0]   ctrl_i,
	input  logic [LANE_N*DATA_W-1:0]   data_i,
	input  logic [LANE_N*KEEP_W-1:0]   keep_i,
	output logic                       ready_o,    // mac word taken
	output logic                       marker_v_o, // markers on the lanes this cycle
	output logic [LANE_N*DATA_W-1:0]   serdes_data_o
);

logic                    pipe_en;   // enc and scrambler advance
logic                    marker_v;
logic [LANE_N-1:0]       gb_accept; // same phase on every lane
pcs_block_t [LANE_N-1:0] enc_blk;   // encoded
pcs_block_t [LANE_N-1:0] scr_blk;   // scrambled
pcs_block_t [LANE_N-1:0] am_blk;    // with markers

// stall on gearbox drain or marker slot
assign pipe_en    = gb_accept[0] & ~marker_v;
assign ready_o    = pipe_en;
assign marker_v_o = marker_v;

for (genvar l = 0; l < LANE_N; l++) begin : gen_enc
	pcs_enc u_enc (
		.pcs_clk (pcs_clk),
		.rst_i   (rst_i),
		.en_i    (pipe_en),
		.ctrl_i  (ctrl_i[l]),
		.data_i  (data_i[l*DATA_W +: DATA_W]),
		.keep_i  (keep_i[l*KEEP_W +: KEEP_W]),
		.block_o (enc_blk[l])
	);
end

pcs_scrambler #(.SCRAM_SEED(SCRAM_SEED)) u_scram (
	.pcs_clk (pcs_clk),
	.rst_i   (rst_i),
	.en_i    (pipe_en),
	.block_i (enc_blk),
	.block_o (scr_blk)
);

// runs on accept alone, it must still emit the marker
pcs_am_insert #(.AM_PERIOD(AM_PERIOD)) u_am (
	.pcs_clk    (pcs_clk),
	.rst_i      (rst_i),
	.en_i       (gb_accept[0]),
	.block_i    (scr_blk),
	.marker_v_o (marker_v),
	.block_o    (am_blk)
);

for (genvar l = 0; l < LANE_N; l++) begin : gen_gb
	pcs_gearbox_tx u_gb (
		.pcs_clk  (pcs_clk),
		.rst_i    (rst_i),
		.block_i  (am_blk[l]),
		.accept_o (gb_accept[l]),
		.data_o   (serdes_data_o[l*DATA_W +: DATA_W])
	);
end

// lane 0 accept drives the whole pipe, the others must track it
a_gb_lockstep: assert property (@(posedge pcs_clk) disable iff (rst_i)
	gb_accept == {LANE_N{gb_accept[0]}});

endmodule

//--- logic/pcs_gearbox_tx.sv
`timescale 1ns/1ps
module pcs_gearbox_tx import pcs_pkg::*; (
	input  logic       pcs_clk,
	input  logic       rst_i,
	input  pcs_block_t block_i,
	output logic       accept_o, // block_i consumed this cycle
	output pcs_data_t  data_o
);

// 33 words of 64b carry 32 blocks of 66b
localparam int PHASE_N = 33;

logic [5:0]          phase_q; // residue holds 2*phase bits
logic [DATA_W-1:0]   res_q;   // pending bits with the lsb leaving first
logic [DATA_W-1:0]   res_d;
logic [2*DATA_W-1:0] cat;     // residue with new block stacked above

// residue is already a full word in the last phase
assign accept_o = (phase_q != 6'(PHASE_N-1));

always_comb begin
	cat = ({{(2*DATA_W-BLOCK_W){1'b0}}, block_i} << (HEAD_W*phase_q))
		| {{DATA_W{1'b0}}, res_q};
	data_o = cat[DATA_W-1:0]; // only the residue in the drain phase
	if (accept_o) begin
		res_d = cat[2*DATA_W-1:DATA_W]; // 2 more bits left over
	end else begin
		res_d = '0; // nothing left after the drain
	end
end

// bits above the valid residue must stay zero for the or above
always_ff @(posedge pcs_clk) begin
	if (rst_i) begin
		phase_q <= '0;
		res_q   <= '0;
	end else begin
		phase_q <= accept_o ? phase_q + 6'd1 : 6'd0;
		res_q   <= res_d;
	end
end

endmodule

//--- logic/pcs_am_insert.sv
`timescale 1ns/1ps
module pcs_am_insert import pcs_pkg::*; #(
	parameter int AM_PERIOD = 16383
)(
	input  logic                    pcs_clk,
	input  logic                    rst_i,
	input  logic                    en_i,     // gearbox takes a block
	input  pcs_block_t [LANE_N-1:0] block_i,
	output logic                    marker_v_o,
	output pcs_block_t [LANE_N-1:0] block_o
);

localparam int CNT_W = $clog2(AM_PERIOD+1);

typedef enum logic {
	AM_DATA,
	AM_MARK
} am_state_t;

am_state_t               state_q;
logic [CNT_W-1:0]        cnt_q;   // data blocks since last marker
logic                    fwd;     // data block leaves this cycle
pcs_block_t [LANE_N-1:0] data_q;  // stage 3 register
logic [LANE_N-1:0][7:0]  bip_q;   // running parity per lane
logic [LANE_N-1:0][7:0]  bip_blk; // parity of the block going out

assign marker_v_o = (state_q == AM_MARK);
assign fwd        = en_i & (state_q == AM_DATA);

// fold each 66b block onto 8 parity bits, bit i lands on i mod 8
always_comb begin
	bip_blk = '0;
	for (int l = 0; l < LANE_N; l++) begin
		for (int i = 0; i < BLOCK_W; i++) begin
			bip_blk[l][i%8] ^= data_q[l][i];
		end
	end
end

always_ff @(posedge pcs_clk) begin
	if (rst_i) begin
		state_q <= AM_DATA;
		cnt_q   <= '0;
		bip_q   <= '0;
	end else if (en_i) begin
		case (state_q)
			AM_DATA: begin
				bip_q <= bip_q ^ bip_blk;
				if (cnt_q == CNT_W'(AM_PERIOD-1)) begin
					cnt_q   <= '0;
					state_q <= AM_MARK; // period done, marker next
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
			AM_MARK: begin
				bip_q   <= '0; // markers themselves not counted
				state_q <= AM_DATA;
			end
			default: state_q <= AM_DATA;
		endcase
	end
end

// held through the marker slot
always_ff @(posedge pcs_clk) begin
	if (rst_i) begin
		data_q <= {LANE_N{IDLE_BLOCK}};
	end else if (fwd) begin
		data_q <= block_i;
	end
end

// marker: M0 M1 M2 BIP, then the same four bytes inverted
always_comb begin
	for (int l = 0; l < LANE_N; l++) begin
		if (marker_v_o) begin
			block_o[l].head = HEAD_CTRL;
			block_o[l].data = {~{bip_q[l], AM_PATTERN[l]}, bip_q[l], AM_PATTERN[l]};
		end else begin
			block_o[l] = data_q[l];
		end
	end
end

// once taken, a marker gives way to data
a_mark_single: assert property (@(posedge pcs_clk) disable iff (rst_i)
	marker_v_o && en_i |=> !marker_v_o);

endmodule

//--- logic/pcs_scrambler.sv
`timescale 1ns/1ps
module pcs_scrambler import pcs_pkg::*; #(
	parameter scram_state_t SCRAM_SEED = '1
)(
	input  logic                    pcs_clk,
	input  logic                    rst_i,
	input  logic                    en_i,
	input  pcs_block_t [LANE_N-1:0] block_i,
	output pcs_block_t [LANE_N-1:0] block_o
);

localparam int STREAM_W = LANE_N*DATA_W; // all four payloads back to back

scram_state_t                state_q; // last 58 scrambled bits, newest at msb
scram_state_t                state_d;
logic [STREAM_W-1:0]         din;
logic [STREAM_W-1:0]         dout;
logic [SCRAM_W+STREAM_W-1:0] hist; // old bits then new, oldest at bit 0

// lane 0 first, bit 0 first within a lane
always_comb begin
	for (int l = 0; l < LANE_N; l++) begin
		din[l*DATA_W +: DATA_W] = block_i[l].data;
	end
	hist = {{STREAM_W{1'b0}}, state_q};
	for (int i = 0; i < STREAM_W; i++) begin
		// s[n] = d[n] ^ s[n-39] ^ s[n-58]
		hist[SCRAM_W+i] = din[i] ^ hist[SCRAM_W+i-SCRAM_TAP] ^ hist[i];
	end
	dout    = hist[SCRAM_W +: STREAM_W];
	state_d = hist[STREAM_W +: SCRAM_W]; // newest 58 bits
end

// stage 2, headers pass unscrambled
always_ff @(posedge pcs_clk) begin
	if (rst_i) begin
		state_q <= SCRAM_SEED;
		block_o <= {LANE_N{IDLE_BLOCK}};
	end else if (en_i) begin
		state_q <= state_d; // only moves with the pipe
		for (int l = 0; l < LANE_N; l++) begin
			block_o[l].data <= dout[l*DATA_W +: DATA_W];
			block_o[l].head <= block_i[l].head;
		end
	end
end

endmodule

//--- logic/pcs_enc.sv
`timescale 1ns/1ps
module pcs_enc import pcs_pkg::*; (
	input  logic        pcs_clk,
	input  logic        rst_i,
	input  logic        en_i,   // pipeline advance
	input  xgmii_ctrl_t ctrl_i,
	input  pcs_data_t   data_i,
	input  pcs_keep_t   keep_i,
	output pcs_block_t  block_o
);

logic [2:0] term_cnt;  // valid bytes in a terminate word
logic       is_err;    // error flag or no usable control flag
pcs_data_t  term_data; // terminate payload
pcs_block_t block_d;

assign is_err = ctrl_i.err_v | ~(ctrl_i.idle_v | ctrl_i.start_v | ctrl_i.term_v);

// terminate: type byte, data bytes, then idle fill
always_comb begin
	term_cnt  = 3'($countones(keep_i));
	term_data = {{8{CC_IDLE}}, BT_TERM[term_cnt]};
	for (int b = 0; b < KEEP_W-1; b++) begin
		if (keep_i[b]) begin
			term_data[8*(b+1) +: 8] = data_i[8*b +: 8]; // byte b moves up one slot
		end
	end
end

always_comb begin
	block_d.head = HEAD_CTRL;
	block_d.data = {{8{CC_IDLE}}, BT_IDLE};
	if (!ctrl_i.ctrl_v) begin
		block_d.head = HEAD_DATA; // plain data, payload untouched
		block_d.data = data_i;
	end else if (is_err) begin
		block_d.data = {{8{CC_ERROR}}, BT_IDLE}; // error codes in every slot
	end else if (ctrl_i.term_v) begin
		block_d.data = term_data;
	end else if (ctrl_i.start_v) begin
		// byte 0 of the word is replaced by the type
		block_d.data = {data_i[DATA_W-1:8], BT_START};
	end
end

// stage 1 register
always_ff @(posedge pcs_clk) begin
	if (rst_i) begin
		block_o <= IDLE_BLOCK;
	end else if (en_i) begin
		block_o <= block_d;
	end
end

// terminate keep must be a run of low bits, byte 7 never valid
a_term_keep: assert property (@(posedge pcs_clk) disable iff (rst_i)
	en_i && ctrl_i.ctrl_v && ctrl_i.term_v && !ctrl_i.err_v
	|-> ((keep_i & (keep_i + 8'd1)) == 8'd0) && !keep_i[KEEP_W-1]);

endmodule

//--- logic/pcs_pkg.sv
package pcs_pkg;

// lane geometry, 40G has four lanes of one block each
localparam int LANE_N    = 4;
localparam int DATA_W    = 64;
localparam int HEAD_W    = 2;
localparam int KEEP_W    = DATA_W/8;
localparam int BLOCK_W   = DATA_W + HEAD_W;
localparam int SCRAM_W   = 58; // x^58 term, scrambler depth
localparam int SCRAM_TAP = 39; // x^39 term

typedef logic [DATA_W-1:0]  pcs_data_t;
typedef logic [KEEP_W-1:0]  pcs_keep_t;
typedef logic [HEAD_W-1:0]  pcs_head_t;
typedef logic [7:0]         pcs_btype_t; // block type field
typedef logic [6:0]         pcs_ccode_t; // 7b control code
typedef logic [23:0]        am_lane_t;   // M0 in low byte
typedef logic [SCRAM_W-1:0] scram_state_t;

// sync header sits in the low bits so it leaves the gearbox first
typedef struct packed {
	pcs_data_t data;
	pcs_head_t head;
} pcs_block_t;

// per lane xgmii control flags
typedef struct packed {
	logic ctrl_v;  // lane carries control
	logic idle_v;
	logic start_v; // start on byte 0 only
	logic term_v;
	logic err_v;
} xgmii_ctrl_t;

localparam pcs_head_t HEAD_DATA = 2'b01;
localparam pcs_head_t HEAD_CTRL = 2'b10;

localparam pcs_btype_t BT_IDLE  = 8'h1e;
localparam pcs_btype_t BT_START = 8'h78;
localparam pcs_btype_t BT_TERM0 = 8'h87;
localparam pcs_btype_t BT_TERM1 = 8'h99;
localparam pcs_btype_t BT_TERM2 = 8'haa;
localparam pcs_btype_t BT_TERM3 = 8'hb4;
localparam pcs_btype_t BT_TERM4 = 8'hcc;
localparam pcs_btype_t BT_TERM5 = 8'hd2;
localparam pcs_btype_t BT_TERM6 = 8'he1;
localparam pcs_btype_t BT_TERM7 = 8'hff;
// indexed by number of valid bytes in the terminate block
localparam pcs_btype_t [7:0] BT_TERM = {BT_TERM7, BT_TERM6, BT_TERM5, BT_TERM4,
	BT_TERM3, BT_TERM2, BT_TERM1, BT_TERM0};

localparam pcs_ccode_t CC_IDLE  = 7'h00;
localparam pcs_ccode_t CC_ERROR = 7'h1e;

// 40GBASE-R marker bytes M0..M2 per lane
localparam am_lane_t AM_PATTERN [LANE_N] = '{24'h477690, 24'he6c4f0, 24'h9b65c5, 24'h3d79a2};

// what every stage holds out of reset
localparam pcs_block_t IDLE_BLOCK = '{data: {{8{CC_IDLE}}, BT_IDLE}, head: HEAD_CTRL};

endpackage
